// ==== logic/hangman_pkg.sv ====
`default_nettype none

package hangman_pkg;

	typedef enum logic [1:0] {
		START    = 2'd0,
		INGAME   = 2'd1,
		WINGAME  = 2'd2,
		LOSTGAME = 2'd3
	} game_state_t;

	// {red, green, blue}
	typedef enum logic [2:0] {
		BLACK = 3'b000,
		WHITE = 3'b111,
		GREEN = 3'b010,
		RED   = 3'b100
	} colour_t;

	localparam int SCREEN_W = 320;
	localparam int SCREEN_H = 240;
	localparam int X_W = 9;
	localparam int Y_W = 8;

	localparam int CELL = 8;
	localparam int GLYPH_W = 64;
	localparam int GLYPH_IDX_W = 5;
	localparam int GLYPH_COUNT = 27;
	localparam logic [GLYPH_IDX_W-1:0] GLYPH_DASH = 5'd26;
	localparam logic [GLYPH_IDX_W-1:0] GLYPH_NONE = 5'd31;

	localparam int LETTERS = 26;
	localparam int WORD_SLOTS = 6;
	localparam int CODE_W = 5;

	localparam int TITLE_X = 30;
	localparam int TITLE_Y = 10;
	localparam int PROMPT_X = 30;
	localparam int PROMPT_Y1 = 20;
	localparam int PROMPT_Y2 = 30;
	localparam int TEXT_PITCH = 10;
	localparam int WORD_X0 = 25;
	localparam int WORD_PITCH = 30;
	localparam int WORD_Y = 190;
	localparam int DASH_Y = 200;
	localparam int PANEL_X1 = 250;
	localparam int PANEL_X2 = 270;
	localparam int PANEL_Y = 10;
	localparam int PANEL_PITCH = 10;
	localparam int RESULT_X = 70;
	localparam int RESULT_Y = 110;
	localparam int BOX_X0 = 20;
	localparam int BOX_X1 = 137;
	localparam int BOX_Y0 = 20;
	localparam int BOX_Y1 = 37;

	// HANGMAN
	localparam logic [GLYPH_IDX_W-1:0] TITLE_TEXT [0:6] =
		'{5'd7, 5'd0, 5'd13, 5'd6, 5'd12, 5'd0, 5'd13};
	// PRESS ENTER
	localparam logic [GLYPH_IDX_W-1:0] PROMPT_TEXT1 [0:10] =
		'{5'd15, 5'd17, 5'd4, 5'd18, 5'd18, GLYPH_NONE, 5'd4, 5'd13, 5'd19, 5'd4, 5'd17};
	// TO START
	localparam logic [GLYPH_IDX_W-1:0] PROMPT_TEXT2 [0:7] =
		'{5'd19, 5'd14, GLYPH_NONE, 5'd18, 5'd19, 5'd0, 5'd17, 5'd19};
	// YOU WIN
	localparam logic [GLYPH_IDX_W-1:0] WIN_TEXT [0:6] =
		'{5'd24, 5'd14, 5'd20, GLYPH_NONE, 5'd22, 5'd8, 5'd13};
	// YOU LOSE
	localparam logic [GLYPH_IDX_W-1:0] LOSE_TEXT [0:7] =
		'{5'd24, 5'd14, 5'd20, GLYPH_NONE, 5'd11, 5'd14, 5'd18, 5'd4};

endpackage

`default_nettype wire

// ==== logic/pixel_scanner.sv ====
`default_nettype none

module pixel_scanner (
	input  logic                        clk,
	input  logic                        reset,
	output logic [hangman_pkg::X_W-1:0] x,
	output logic [hangman_pkg::Y_W-1:0] y
);
	import hangman_pkg::*;

	// Row-major raster, one pixel per clock
	always_ff @(posedge clk) begin
		if (reset) begin
			x <= '0;
			y <= '0;
		end else if (x == X_W'(SCREEN_W - 1)) begin
			x <= '0;
			if (y == Y_W'(SCREEN_H - 1))
				y <= '0;
			else
				y <= y + 1'b1;
		end else begin
			x <= x + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/tile_decoder.sv ====
`default_nettype none

module tile_decoder (
	input  logic                                                 clk,
	input  logic                                                 reset,
	input  logic [hangman_pkg::X_W-1:0]                          x,
	input  logic [hangman_pkg::Y_W-1:0]                          y,
	input  hangman_pkg::game_state_t                             game_state,
	input  logic [hangman_pkg::WORD_SLOTS*hangman_pkg::CODE_W-1:0] word,
	input  logic [hangman_pkg::LETTERS-1:0]                      mask,
	input  logic [hangman_pkg::LETTERS-1:0]                      guessed_mask,
	output logic [hangman_pkg::GLYPH_IDX_W-1:0]                  glyph_idx,
	output logic [5:0]                                           bit_pos,
	output logic [hangman_pkg::X_W-1:0]                          pixel_x,
	output logic [hangman_pkg::Y_W-1:0]                          pixel_y,
	output hangman_pkg::colour_t                                 cell_colour,
	output logic                                                 cell_plot,
	output logic                                                 glyph_valid,
	output logic [5:0]                                           pixel_bit
);
	import hangman_pkg::*;

	int px;
	int py;
	logic drawn;
	logic game_over;
	logic in_box;
	colour_t colour;
	logic [CODE_W-1:0] code;
	logic [GLYPH_IDX_W-1:0] letter;

	function automatic logic in_cell(input int ax, input int ay, input int cx, input int cy);
		return (ax >= cx) && (ax < cx + CELL) && (ay >= cy) && (ay < cy + CELL);
	endfunction

	// Rows count up from the bottom line of the cell
	function automatic logic [5:0] cell_bit(input int ax, input int ay, input int cx, input int cy);
		int col;
		int row;
		col = ax - cx;
		row = CELL - 1 - (ay - cy);
		return {row[2:0], col[2:0]};
	endfunction

	// Later regions override earlier ones
	always_comb begin
		px = int'(x);
		py = int'(y);
		game_over = (game_state == WINGAME) || (game_state == LOSTGAME);
		glyph_idx = GLYPH_NONE;
		bit_pos = '0;
		colour = BLACK;
		drawn = 1'b0;
		code = '0;
		letter = '0;

		for (int i = 0; i < $size(TITLE_TEXT); i++) begin
			if (in_cell(px, py, TITLE_X + i * TEXT_PITCH, TITLE_Y)) begin
				{drawn, glyph_idx} = {1'b1, TITLE_TEXT[i]};
				bit_pos = cell_bit(px, py, TITLE_X + i * TEXT_PITCH, TITLE_Y);
				colour = WHITE;
			end
		end

		if (game_state == START) begin
			for (int i = 0; i < $size(PROMPT_TEXT1); i++) begin
				if (in_cell(px, py, PROMPT_X + i * TEXT_PITCH, PROMPT_Y1)) begin
					{drawn, glyph_idx} = {1'b1, PROMPT_TEXT1[i]};
					bit_pos = cell_bit(px, py, PROMPT_X + i * TEXT_PITCH, PROMPT_Y1);
					colour = WHITE;
				end
			end
			for (int i = 0; i < $size(PROMPT_TEXT2); i++) begin
				if (in_cell(px, py, PROMPT_X + i * TEXT_PITCH, PROMPT_Y2)) begin
					{drawn, glyph_idx} = {1'b1, PROMPT_TEXT2[i]};
					bit_pos = cell_bit(px, py, PROMPT_X + i * TEXT_PITCH, PROMPT_Y2);
					colour = WHITE;
				end
			end
		end else begin
			// Word letters with a dash below each slot
			for (int s = 0; s < WORD_SLOTS; s++) begin
				code = word[(WORD_SLOTS - 1 - s) * CODE_W +: CODE_W];
				letter = code - 1'b1;
				if (in_cell(px, py, WORD_X0 + s * WORD_PITCH, WORD_Y)) begin
					drawn = 1'b1;
					bit_pos = cell_bit(px, py, WORD_X0 + s * WORD_PITCH, WORD_Y);
					// Empty slot keeps a blank cell
					if ((code != '0) && (int'(code) <= LETTERS)) begin
						glyph_idx = letter;
						colour = (guessed_mask[letter] || game_over) ? WHITE : BLACK;
					end else begin
						glyph_idx = GLYPH_NONE;
						colour = BLACK;
					end
				end
				if (in_cell(px, py, WORD_X0 + s * WORD_PITCH, DASH_Y)) begin
					{drawn, glyph_idx} = {1'b1, GLYPH_DASH};
					bit_pos = cell_bit(px, py, WORD_X0 + s * WORD_PITCH, DASH_Y);
					colour = WHITE;
				end
			end

			// Alphabet panel, A to M then N to Z
			for (int i = 0; i < LETTERS; i++) begin
				if (in_cell(px, py, (i < LETTERS / 2) ? PANEL_X1 : PANEL_X2,
						PANEL_Y + (i % (LETTERS / 2)) * PANEL_PITCH)) begin
					{drawn, glyph_idx} = {1'b1, GLYPH_IDX_W'(i)};
					bit_pos = cell_bit(px, py, (i < LETTERS / 2) ? PANEL_X1 : PANEL_X2,
						PANEL_Y + (i % (LETTERS / 2)) * PANEL_PITCH);
					colour = (guessed_mask[i] && !mask[i]) ? RED : GREEN;
				end
			end

			if (game_state == WINGAME) begin
				for (int i = 0; i < $size(WIN_TEXT); i++) begin
					if (in_cell(px, py, RESULT_X + i * TEXT_PITCH, RESULT_Y) &&
							(WIN_TEXT[i] != GLYPH_NONE)) begin
						{drawn, glyph_idx} = {1'b1, WIN_TEXT[i]};
						bit_pos = cell_bit(px, py, RESULT_X + i * TEXT_PITCH, RESULT_Y);
						colour = WHITE;
					end
				end
			end
			if (game_state == LOSTGAME) begin
				for (int i = 0; i < $size(LOSE_TEXT); i++) begin
					if (in_cell(px, py, RESULT_X + i * TEXT_PITCH, RESULT_Y) &&
							(LOSE_TEXT[i] != GLYPH_NONE)) begin
						{drawn, glyph_idx} = {1'b1, LOSE_TEXT[i]};
						bit_pos = cell_bit(px, py, RESULT_X + i * TEXT_PITCH, RESULT_Y);
						colour = WHITE;
					end
				end
			end
		end

		// Prompt box is overwritten with black once the game runs
		in_box = (px >= BOX_X0) && (px <= BOX_X1) && (py >= BOX_Y0) && (py <= BOX_Y1);
	end

	// Aligns the cell data with the ROM read
	always_ff @(posedge clk) begin
		pixel_x <= x;
		pixel_y <= y;
		cell_colour <= colour;
		pixel_bit <= bit_pos;
		if (reset) begin
			cell_plot <= 1'b0;
			glyph_valid <= 1'b0;
		end else begin
			cell_plot <= drawn || (game_state == START) || in_box;
			glyph_valid <= int'(glyph_idx) < GLYPH_COUNT;
		end
	end

endmodule

`default_nettype wire

// ==== logic/glyph_rom.sv ====
`default_nettype none

module glyph_rom (
	input  logic                                clk,
	input  logic [hangman_pkg::GLYPH_IDX_W-1:0] glyph_idx,
	output logic [hangman_pkg::GLYPH_W-1:0]     glyph_bits
);
	import hangman_pkg::*;

	// A to Z, then the dash
	logic [GLYPH_W-1:0] mem [0:GLYPH_COUNT-1];

	initial begin
		$readmemh("glyphs.mem", mem);
	end

	always_ff @(posedge clk) begin
		// Blank cells read as all zero
		if (int'(glyph_idx) < GLYPH_COUNT)
			glyph_bits <= mem[glyph_idx];
		else
			glyph_bits <= '0;
	end

endmodule

`default_nettype wire

// ==== logic/hangman_display.sv ====
`default_nettype none

module hangman_display (
	input  logic                                                 clk,
	input  logic                                                 reset,
	input  hangman_pkg::game_state_t                             game_state,
	input  logic [hangman_pkg::WORD_SLOTS*hangman_pkg::CODE_W-1:0] word,
	input  logic [hangman_pkg::LETTERS-1:0]                      mask,
	input  logic [hangman_pkg::LETTERS-1:0]                      guessed_mask,
	output logic [hangman_pkg::X_W-1:0]                          plot_x,
	output logic [hangman_pkg::Y_W-1:0]                          plot_y,
	output hangman_pkg::colour_t                                 plot_colour,
	output logic                                                 plot
);
	import hangman_pkg::*;

	logic [X_W-1:0] x;
	logic [Y_W-1:0] y;
	logic [GLYPH_IDX_W-1:0] glyph_idx;
	logic [GLYPH_W-1:0] glyph_bits;
	logic [5:0] pixel_bit;
	colour_t cell_colour;
	logic glyph_valid;

	pixel_scanner scanner (
		.clk   (clk),
		.reset (reset),
		.x     (x),
		.y     (y)
	);

	tile_decoder decoder (
		.clk          (clk),
		.reset        (reset),
		.x            (x),
		.y            (y),
		.game_state   (game_state),
		.word         (word),
		.mask         (mask),
		.guessed_mask (guessed_mask),
		.glyph_idx    (glyph_idx),
		.bit_pos      (),
		.pixel_x      (plot_x),
		.pixel_y      (plot_y),
		.cell_colour  (cell_colour),
		.cell_plot    (plot),
		.glyph_valid  (glyph_valid),
		.pixel_bit    (pixel_bit)
	);

	glyph_rom rom (
		.clk        (clk),
		.glyph_idx  (glyph_idx),
		.glyph_bits (glyph_bits)
	);

	// Glyph bit picks between cell colour and background
	assign plot_colour = (glyph_valid && glyph_bits[pixel_bit]) ? cell_colour : BLACK;

endmodule

`default_nettype wire

// ==== test/display_checker.sv ====
`default_nettype none

module display_checker (
	input  logic                                                   clk,
	input  logic                                                   reset,
	input  hangman_pkg::game_state_t                               game_state,
	input  logic [hangman_pkg::WORD_SLOTS*hangman_pkg::CODE_W-1:0] word,
	input  logic [hangman_pkg::LETTERS-1:0]                        mask,
	input  logic [hangman_pkg::LETTERS-1:0]                        guessed_mask,
	input  logic [hangman_pkg::X_W-1:0]                            plot_x,
	input  logic [hangman_pkg::Y_W-1:0]                            plot_y,
	input  hangman_pkg::colour_t                                   plot_colour,
	input  logic                                                   plot,
	output int                                                     errors,
	output int                                                     pixels
);
	import hangman_pkg::*;

	logic [GLYPH_W-1:0] glyphs [0:GLYPH_COUNT-1];
	logic reset_d;
	game_state_t state_d;
	logic [WORD_SLOTS*CODE_W-1:0] word_d;
	logic [LETTERS-1:0] mask_d;
	logic [LETTERS-1:0] guessed_d;
	int exp_x;
	int exp_y;
	logic [3:0] expected;

	function automatic logic hit(input int ax, input int ay, input int cx, input int cy);
		return ax - cx >= 0 && ax - cx < CELL && ay - cy >= 0 && ay - cy < CELL;
	endfunction

	// Returns {plot, colour} for one pixel
	function automatic logic [3:0] reference_pixel(input int ax, input int ay,
			input game_state_t st, input logic [WORD_SLOTS*CODE_W-1:0] w,
			input logic [LETTERS-1:0] m, input logic [LETTERS-1:0] g);
		int idx;
		int cx;
		int cy;
		int code;
		logic drawn;
		colour_t c;
		idx = GLYPH_NONE;
		cx = 0;
		cy = 0;
		drawn = 0;
		c = BLACK;
		for (int i = 0; i < 7; i++)
			if (hit(ax, ay, TITLE_X + TEXT_PITCH * i, TITLE_Y)) begin
				{drawn, idx, c, cx, cy} = {1'b1, int'(TITLE_TEXT[i]), WHITE,
					TITLE_X + TEXT_PITCH * i, TITLE_Y};
			end
		if (st == START) begin
			for (int i = 0; i < 11; i++)
				if (hit(ax, ay, PROMPT_X + TEXT_PITCH * i, PROMPT_Y1)) begin
					{drawn, idx, c, cx, cy} = {1'b1, int'(PROMPT_TEXT1[i]), WHITE,
						PROMPT_X + TEXT_PITCH * i, PROMPT_Y1};
				end
			for (int i = 0; i < 8; i++)
				if (hit(ax, ay, PROMPT_X + TEXT_PITCH * i, PROMPT_Y2)) begin
					{drawn, idx, c, cx, cy} = {1'b1, int'(PROMPT_TEXT2[i]), WHITE,
						PROMPT_X + TEXT_PITCH * i, PROMPT_Y2};
				end
		end else begin
			for (int s = 0; s < WORD_SLOTS; s++) begin
				code = int'(w[CODE_W*(WORD_SLOTS-1-s) +: CODE_W]);
				if (hit(ax, ay, WORD_X0 + WORD_PITCH * s, WORD_Y)) begin
					{drawn, cx, cy, idx, c} = {1'b1, WORD_X0 + WORD_PITCH * s, WORD_Y,
						int'(GLYPH_NONE), BLACK};
					if (code >= 1 && code <= LETTERS) begin
						idx = code - 1;
						if (g[code-1] || st != INGAME)
							c = WHITE;
					end
				end else if (hit(ax, ay, WORD_X0 + WORD_PITCH * s, DASH_Y)) begin
					{drawn, cx, cy, idx, c} = {1'b1, WORD_X0 + WORD_PITCH * s, DASH_Y,
						int'(GLYPH_DASH), WHITE};
				end
			end
			for (int i = 0; i < LETTERS; i++) begin
				if (hit(ax, ay, i < 13 ? PANEL_X1 : PANEL_X2, PANEL_Y + PANEL_PITCH * (i % 13))) begin
					{drawn, idx} = {1'b1, i};
					cx = i < 13 ? PANEL_X1 : PANEL_X2;
					cy = PANEL_Y + PANEL_PITCH * (i % 13);
					c = (g[i] && !m[i]) ? RED : GREEN;
				end
			end
			for (int i = 0; i < 8; i++) begin
				code = (st == WINGAME) ? (i < 7 ? int'(WIN_TEXT[i]) : int'(GLYPH_NONE)) :
					(st == LOSTGAME) ? int'(LOSE_TEXT[i]) : int'(GLYPH_NONE);
				if (code != GLYPH_NONE && hit(ax, ay, RESULT_X + TEXT_PITCH * i, RESULT_Y)) begin
					{drawn, idx, c, cx, cy} = {1'b1, code, WHITE,
						RESULT_X + TEXT_PITCH * i, RESULT_Y};
				end
			end
		end
		drawn = drawn || st == START ||
			(ax >= BOX_X0 && ax <= BOX_X1 && ay >= BOX_Y0 && ay <= BOX_Y1);
		if (idx >= GLYPH_COUNT || !glyphs[idx][(CELL - 1 - (ay - cy)) * CELL + (ax - cx)])
			c = BLACK;
		return {drawn, c};
	endfunction

	initial begin
		$readmemh("glyphs.mem", glyphs);
		errors = 0;
		pixels = 0;
		exp_x = 0;
		exp_y = 0;
	end

	// Output register captured what the DUT saw at the last rising edge
	always @(posedge clk) begin
		reset_d <= reset;
		state_d <= game_state;
		word_d <= word;
		mask_d <= mask;
		guessed_d <= guessed_mask;
	end

	always @(negedge clk) begin
		if (reset_d === 1'b1) begin
			exp_x = 0;
			exp_y = 0;
			if (plot !== 1'b0) begin
				$display("error at %0t: plot expected 0 got %b", $time, plot);
				errors++;
			end
		end else if (reset_d === 1'b0) begin
			expected = reference_pixel(exp_x, exp_y, state_d, word_d, mask_d, guessed_d);
			if (plot_x !== X_W'(exp_x) || plot_y !== Y_W'(exp_y)) begin
				$display("error at %0t: plot_x/plot_y expected %0d,%0d got %0d,%0d",
					$time, exp_x, exp_y, plot_x, plot_y);
				errors++;
			end
			if (plot !== expected[3]) begin
				$display("error at %0t: plot expected %b got %b", $time, expected[3], plot);
				errors++;
			end
			if (plot_colour !== expected[2:0]) begin
				$display("error at %0t: plot_colour expected %b got %b",
					$time, expected[2:0], plot_colour);
				errors++;
			end
			pixels++;
			exp_x = (exp_x == SCREEN_W - 1) ? 0 : exp_x + 1;
			if (exp_x == 0)
				exp_y = (exp_y == SCREEN_H - 1) ? 0 : exp_y + 1;
		end
	end

endmodule

`default_nettype wire

// ==== test/hangman_display_tb.sv ====
`default_nettype none

module hangman_display_tb;
	import hangman_pkg::*;

	logic clk;
	logic reset;
	game_state_t game_state;
	logic [WORD_SLOTS*CODE_W-1:0] word;
	logic [LETTERS-1:0] mask;
	logic [LETTERS-1:0] guessed_mask;
	logic [X_W-1:0] plot_x;
	logic [Y_W-1:0] plot_y;
	colour_t plot_colour;
	logic plot;
	int errors;
	int pixels;
	int code;

	hangman_display UUT (
		.clk          (clk),
		.reset        (reset),
		.game_state   (game_state),
		.word         (word),
		.mask         (mask),
		.guessed_mask (guessed_mask),
		.plot_x       (plot_x),
		.plot_y       (plot_y),
		.plot_colour  (plot_colour),
		.plot         (plot)
	);

	display_checker checks (
		.clk          (clk),
		.reset        (reset),
		.game_state   (game_state),
		.word         (word),
		.mask         (mask),
		.guessed_mask (guessed_mask),
		.plot_x       (plot_x),
		.plot_y       (plot_y),
		.plot_colour  (plot_colour),
		.plot         (plot),
		.errors       (errors),
		.pixels       (pixels)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Returns on the falling edge that shows the last pixel of a frame
	task automatic wait_frame_end();
		int count;
		count = 0;
		@(negedge clk);
		while (!(plot_x == X_W'(SCREEN_W - 1) && plot_y == Y_W'(SCREEN_H - 1) && !reset)) begin
			count++;
			if (count > SCREEN_W * SCREEN_H + 16) begin
				$display("Timed out waiting for the end of a frame");
				$display("Simulation failed");
				$finish;
			end
			@(negedge clk);
		end
	endtask

	initial begin
		void'($urandom(54));
		reset = 1'b1;
		game_state = START;
		word = '0;
		mask = '0;
		guessed_mask = '0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		wait_frame_end();

		game_state = INGAME;
		for (int s = 0; s < WORD_SLOTS; s++) begin
			code = $urandom_range(1, LETTERS);
			word[CODE_W*s +: CODE_W] = CODE_W'(code);
			mask[code-1] = 1'b1;
		end
		guessed_mask = LETTERS'($urandom);
		wait_frame_end();

		game_state = WINGAME;
		wait_frame_end();
		game_state = LOSTGAME;
		wait_frame_end();

		// Last pixel is compared on that same falling edge
		@(posedge clk);

		$display("Pixels checked: %0d, errors: %0d", pixels, errors);
		if (errors == 0 && pixels == 4 * SCREEN_W * SCREEN_H)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== glyphs.mem ====
// One 64-bit glyph per line, A to Z then the dash
// Top byte is the top row of the cell, bit 0 of each byte is the left column
183C66667E666600
3E66663E66663E00
3C66060606663C00
1E36666666361E00
7E06061E06067E00
7E06061E06060600
3C66067666663C00
6666667E66666600
3C18181818183C00
7830303030361C00
66361E0E1E366600
0606060606067E00
C6EEFED6C6C6C600
C6CEDEF6E6C6C600
3C66666666663C00
3E66663E06060600
3C666666663C7000
3E66663E1E366600
3C66063C60663C00
7E18181818181800
6666666666663C00
66666666663C1800
C6C6C6D6FEEEC600
66663C183C666600
6666663C18181800
7E6030180C067E00
000000007E000000

// ==== files.f ====
logic/hangman_pkg.sv
logic/pixel_scanner.sv
logic/tile_decoder.sv
logic/glyph_rom.sv
logic/hangman_display.sv
test/display_checker.sv
test/hangman_display_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = hangman_display_tb
RTL_TOP   = hangman_display
FILELIST  = files.f
LOG       = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
